// ==== src/vdp_cmd_pkg.sv ====
/*
  Shared definitions for the VDP command engine
  Command and operation codes, register indices, field widths, FSM states
*/
package vdp_cmd_pkg;

  // Field widths
  typedef logic [8:0]  coord_x_t;
  typedef logic [9:0]  coord_y_t;
  typedef logic [9:0]  count_t;
  typedef logic [16:0] vram_addr_t;
  typedef logic [7:0]  pixel_t;
  typedef logic [3:0]  reg_num_t;
  typedef logic [3:0]  cmd_code_t;
  typedef logic [3:0]  log_op_t;

  // Command codes, upper nibble of CMR
  localparam cmd_code_t CMD_STOP  = 4'b0000;
  localparam cmd_code_t CMD_POINT = 4'b0100;
  localparam cmd_code_t CMD_PSET  = 4'b0101;
  localparam cmd_code_t CMD_LMMV  = 4'b1000;
  localparam cmd_code_t CMD_HMMV  = 4'b1100;

  // Logical operations, lower nibble of CMR
  localparam log_op_t OP_IMP = 4'b0000;
  localparam log_op_t OP_AND = 4'b0001;
  localparam log_op_t OP_OR  = 4'b0010;
  localparam log_op_t OP_XOR = 4'b0011;
  localparam log_op_t OP_NOT = 4'b0100;
  // Set for the transparent variants
  localparam int OP_T_BIT = 3;

  // Register indices, R32 upward
  localparam reg_num_t REG_SX_L = 4'd0;
  localparam reg_num_t REG_SX_H = 4'd1;
  localparam reg_num_t REG_SY_L = 4'd2;
  localparam reg_num_t REG_SY_H = 4'd3;
  localparam reg_num_t REG_DX_L = 4'd4;
  localparam reg_num_t REG_DX_H = 4'd5;
  localparam reg_num_t REG_DY_L = 4'd6;
  localparam reg_num_t REG_DY_H = 4'd7;
  localparam reg_num_t REG_NX_L = 4'd8;
  localparam reg_num_t REG_NX_H = 4'd9;
  localparam reg_num_t REG_NY_L = 4'd10;
  localparam reg_num_t REG_NY_H = 4'd11;
  localparam reg_num_t REG_CLR  = 4'd12;
  localparam reg_num_t REG_ARG  = 4'd13;
  localparam reg_num_t REG_CMR  = 4'd14;

  // Colour masks for the logical commands
  localparam pixel_t G4_COLMASK = 8'h0F;
  localparam pixel_t G7_COLMASK = 8'hFF;

  // X counter bit set once the screen edge is passed
  localparam int X_END_BIT = 8;

  typedef enum logic [3:0] {
    IDLE,
    CHK_LOOP,
    RD_VRAM,
    WAIT_RD_VRAM,
    PRE_RD_VRAM,
    WAIT_PRE_RD_VRAM,
    WR_VRAM,
    WAIT_WR_VRAM,
    EXEC_END
  } cmd_state_t;

endpackage

// ==== src/vdp_cmd_regs.sv ====
`timescale 1ns/100ps
/*
  VDP command register file
  Host writes arrive over a toggle request/acknowledge port,
  the sequencer writes back DY, NY and the colour register
*/
module vdp_cmd_regs import vdp_cmd_pkg::*; (
  input  logic      reset,
  input  logic      clk,
  input  logic      cmd_enable,
  input  logic      reg_wr_req,
  input  reg_num_t  reg_num,
  input  pixel_t    reg_data,
  input  logic      ce,
  input  logic      line_step,
  input  coord_y_t  dy_next,
  input  count_t    ny_next,
  input  logic      clr_load,
  input  pixel_t    clr_value,
  input  pixel_t    colmask,
  output logic      reg_wr_ack,
  output coord_x_t  sx,
  output coord_x_t  dx,
  output coord_y_t  sy,
  output coord_y_t  dy,
  output count_t    nx,
  output count_t    ny,
  output pixel_t    clr,
  output log_op_t   log_op,
  output logic      dix,
  output logic      diy,
  output cmd_code_t cmd,
  output logic      cmd_start
);

  logic wr_pending;

  // Request differs from ack while a write waits
  assign wr_pending = reg_wr_req != reg_wr_ack;

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      reg_wr_ack <= 1'b0;
      sx         <= '0;
      dx         <= '0;
      sy         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      clr        <= '0;
      log_op     <= '0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmd        <= CMD_STOP;
      cmd_start  <= 1'b0;
    end else begin
      cmd_start <= 1'b0;
      // Row advance from the sequencer
      if (line_step) begin
        dy <= dy_next;
        ny <= ny_next;
      end
      // POINT result
      if (clr_load) begin
        clr <= clr_value;
      end
      // Host write wins over the write-back
      if (wr_pending) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_SX_L: sx[7:0] <= reg_data;
          REG_SX_H: sx[8]   <= reg_data[0];
          REG_SY_L: sy[7:0] <= reg_data;
          REG_SY_H: sy[9:8] <= reg_data[1:0];
          REG_DX_L: dx[7:0] <= reg_data;
          REG_DX_H: dx[8]   <= reg_data[0];
          REG_DY_L: dy[7:0] <= reg_data;
          REG_DY_H: dy[9:8] <= reg_data[1:0];
          REG_NX_L: nx[7:0] <= reg_data;
          REG_NX_H: nx[9:8] <= reg_data[1:0];
          REG_NY_L: ny[7:0] <= reg_data;
          REG_NY_H: ny[9:8] <= reg_data[1:0];
          // Masked to the pixel width while a command runs
          REG_CLR:  clr <= ce ? (reg_data & colmask) : reg_data;
          REG_ARG: begin
            dix <= reg_data[2];
            diy <= reg_data[3];
          end
          REG_CMR: begin
            cmd       <= reg_data[7:4];
            log_op    <= reg_data[3:0];
            // Also aborts whatever is running
            cmd_start <= cmd_enable;
          end
          default: ;
        endcase
      end
    end
  end

  // Ack toggles only in answer to a pending host write
  ack_on_pending: assert property (@(posedge reset) disable iff (clk)
    $changed(reg_wr_ack) |-> $past(wr_pending));

endmodule

// ==== src/vdp_cmd_seq.sv ====
`timescale 1ns/100ps
/*
  VDP command sequencer
  Walks the rectangle or single pixel, runs the VRAM toggle handshake
  and writes DY, NY and the POINT colour back to the register file
*/
module vdp_cmd_seq import vdp_cmd_pkg::*; (
  input  logic       reset,
  input  logic       clk,
  input  logic       mode_graphic_4,
  input  coord_x_t   sx,
  input  coord_y_t   sy,
  input  coord_x_t   dx,
  input  coord_y_t   dy,
  input  count_t     nx,
  input  count_t     ny,
  input  logic       dix,
  input  logic       diy,
  input  cmd_code_t  cmd,
  input  logic       cmd_start,
  input  logic       vram_rd_ack,
  input  logic       vram_wr_ack,
  input  pixel_t     merged_byte,
  input  pixel_t     read_pixel,
  output logic       ce,
  output logic       vram_rd_req,
  output logic       vram_wr_req,
  output vram_addr_t vram_addr,
  output pixel_t     vram_wr_data,
  output logic       pix_x_low,
  output logic       is_byte_cmd,
  output logic       line_step,
  output coord_y_t   dy_next,
  output count_t     ny_next,
  output logic       clr_load,
  output pixel_t     clr_value
);

  cmd_state_t state;
  // One bit wider than X so the edge bit can be seen in both directions
  logic [9:0] dx_tmp;
  logic [9:0] x_step;
  count_t     nx_tmp;
  count_t     nx_count;
  coord_y_t   y_step;
  coord_x_t   acc_x;
  coord_y_t   acc_y;
  logic       initializing;
  logic       start_pend;
  logic       row_end;
  logic       rect_end;
  logic       is_draw;
  logic       rd_idle;
  logic       wr_idle;

  assign is_byte_cmd = cmd[3:2] == 2'b11;
  assign is_draw     = (cmd == CMD_POINT) || (cmd == CMD_PSET) ||
                       (cmd == CMD_LMMV) || (cmd == CMD_HMMV);
  assign rd_idle     = vram_rd_req == vram_rd_ack;
  assign wr_idle     = vram_wr_req == vram_wr_ack;

  // HMMV in Graphic 4 moves a byte, two pixels, per step
  always_comb begin
    if (is_byte_cmd && mode_graphic_4) begin
      x_step   = dix ? 10'h3FE : 10'h002;
      nx_count = {1'b0, nx[9:1]};
    end else begin
      x_step   = dix ? 10'h3FF : 10'h001;
      nx_count = nx;
    end
  end

  assign y_step   = diy ? '1 : coord_y_t'(1);
  assign row_end  = (nx_tmp == '0) || dx_tmp[X_END_BIT];
  assign rect_end = (ny == count_t'(1)) || (diy && (dy == '0));

  // Row advance written back in the CHK_LOOP cycle itself
  assign dy_next   = dy + y_step;
  assign ny_next   = ny - count_t'(1);
  assign line_step = (state == CHK_LOOP) && !initializing && row_end;

  // POINT read lands straight in the colour register
  assign clr_load  = (state == WAIT_RD_VRAM) && rd_idle;
  assign clr_value = read_pixel;

  // Byte address per mode
  always_comb begin
    if (mode_graphic_4) begin
      vram_addr = {acc_y, acc_x[7:1]};
    end else begin
      vram_addr = {acc_y[8:0], acc_x[7:0]};
    end
  end

  // Access coordinates and write data
  always_ff @(posedge reset) begin
    case (state)
      RD_VRAM: begin
        acc_x     <= sx;
        acc_y     <= sy;
        pix_x_low <= sx[0];
      end
      PRE_RD_VRAM: begin
        acc_x     <= dx_tmp[8:0];
        acc_y     <= dy;
        pix_x_low <= dx_tmp[0];
      end
      WR_VRAM: begin
        acc_x        <= dx_tmp[8:0];
        acc_y        <= dy;
        vram_wr_data <= merged_byte;
      end
      default: ;
    endcase
  end

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      state        <= IDLE;
      ce           <= 1'b0;
      vram_rd_req  <= 1'b0;
      vram_wr_req  <= 1'b0;
      dx_tmp       <= '0;
      nx_tmp       <= '0;
      initializing <= 1'b0;
      start_pend   <= 1'b0;
    end else if (cmd_start) begin
      // Abort, ce stays up when another drawing command follows
      state      <= IDLE;
      start_pend <= is_draw;
      ce         <= ce & is_draw;
    end else begin
      case (state)
        IDLE: begin
          // Let an aborted access finish first
          if (start_pend && rd_idle && wr_idle) begin
            start_pend   <= 1'b0;
            ce           <= 1'b1;
            dx_tmp       <= {1'b0, dx};
            nx_tmp       <= nx_count;
            initializing <= 1'b1;
            state        <= CHK_LOOP;
          end else if (!start_pend) begin
            ce <= 1'b0;
          end
        end
        CHK_LOOP: begin
          initializing <= 1'b0;
          if (!initializing && row_end) begin
            dx_tmp <= {1'b0, dx};
            nx_tmp <= nx_count;
          end
          if (!initializing && row_end && rect_end) begin
            state <= EXEC_END;
          end else begin
            case (cmd)
              CMD_HMMV:           state <= WR_VRAM;
              CMD_LMMV, CMD_PSET: state <= PRE_RD_VRAM;
              CMD_POINT:          state <= RD_VRAM;
              default:            state <= EXEC_END;
            endcase
          end
        end
        RD_VRAM: begin
          vram_rd_req <= ~vram_rd_ack;
          state       <= WAIT_RD_VRAM;
        end
        WAIT_RD_VRAM: begin
          if (rd_idle) begin
            state <= EXEC_END;
          end
        end
        PRE_RD_VRAM: begin
          vram_rd_req <= ~vram_rd_ack;
          state       <= WAIT_PRE_RD_VRAM;
        end
        WAIT_PRE_RD_VRAM: begin
          if (rd_idle) begin
            state <= WR_VRAM;
          end
        end
        WR_VRAM: begin
          vram_wr_req <= ~vram_wr_ack;
          state       <= WAIT_WR_VRAM;
        end
        WAIT_WR_VRAM: begin
          if (wr_idle) begin
            if (cmd == CMD_PSET) begin
              state <= EXEC_END;
            end else begin
              dx_tmp <= dx_tmp + x_step;
              nx_tmp <= nx_tmp - count_t'(1);
              state  <= CHK_LOOP;
            end
          end
        end
        EXEC_END: begin
          ce    <= 1'b0;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Reads and writes never overlap on the VRAM port
  single_access: assert property (@(posedge reset) disable iff (clk)
    rd_idle || wr_idle);

  // Busy flag covers every active state
  ce_when_busy: assert property (@(posedge reset) disable iff (clk)
    (state != IDLE) |-> ce);

endmodule

// ==== src/vdp_pixel_op.sv ====
`timescale 1ns/100ps
/*
  VDP pixel unit
  Extracts the addressed pixel, applies the logical operation
  and merges the result back into the VRAM byte
*/
module vdp_pixel_op import vdp_cmd_pkg::*; (
  input  logic    mode_graphic_4,
  input  logic    is_byte_cmd,
  input  logic    pix_x_low,
  input  log_op_t log_op,
  input  pixel_t  clr,
  input  pixel_t  rd_byte,
  output pixel_t  read_pixel,
  output pixel_t  merged_byte,
  output pixel_t  colmask
);

  log_op_t base_op;
  pixel_t  src;
  pixel_t  result;

  // Byte commands move whole bytes
  always_comb begin
    if (is_byte_cmd) begin
      colmask = 8'hFF;
    end else if (mode_graphic_4) begin
      colmask = G4_COLMASK;
    end else begin
      colmask = G7_COLMASK;
    end
  end

  // Even X sits in the high nibble
  always_comb begin
    if (mode_graphic_4) begin
      read_pixel = pix_x_low ? {4'h0, rd_byte[3:0]} : {4'h0, rd_byte[7:4]};
    end else begin
      read_pixel = rd_byte;
    end
  end

  assign base_op = {1'b0, log_op[2:0]};
  assign src     = clr & colmask;

  always_comb begin
    // Transparent with zero source keeps the destination
    if (!log_op[OP_T_BIT] || (src != '0)) begin
      case (base_op)
        OP_IMP:  result = src;
        OP_AND:  result = src & read_pixel;
        OP_OR:   result = src | read_pixel;
        OP_XOR:  result = src ^ read_pixel;
        OP_NOT:  result = ~src;
        default: result = read_pixel;
      endcase
    end else begin
      result = read_pixel;
    end
  end

  // Only the addressed nibble changes in Graphic 4
  always_comb begin
    if (is_byte_cmd) begin
      merged_byte = clr;
    end else if (mode_graphic_4) begin
      merged_byte = pix_x_low ? {rd_byte[7:4], result[3:0]} : {result[3:0], rd_byte[3:0]};
    end else begin
      merged_byte = result;
    end
  end

endmodule

// ==== src/vdp_cmd_top.sv ====
`timescale 1ns/100ps
/*
  VDP command engine top level
  Register file, sequencer and pixel unit behind two toggle handshakes
*/
module vdp_cmd_top import vdp_cmd_pkg::*; (
  input  logic       reset,
  input  logic       clk,
  input  logic       mode_graphic_4,
  input  logic       mode_graphic_7,
  input  logic       reg_wr_req,
  input  reg_num_t   reg_num,
  input  pixel_t     reg_data,
  input  logic       vram_wr_ack,
  input  logic       vram_rd_ack,
  input  pixel_t     vram_rd_data,
  output logic       reg_wr_ack,
  output logic       vram_wr_req,
  output logic       vram_rd_req,
  output vram_addr_t vram_addr,
  output pixel_t     vram_wr_data,
  output pixel_t     clr,
  output logic       ce,
  output cmd_code_t  current_command
);

  coord_x_t sx;
  coord_x_t dx;
  coord_y_t sy;
  coord_y_t dy;
  count_t   nx;
  count_t   ny;
  log_op_t  log_op;
  logic     dix;
  logic     diy;
  logic     cmd_start;
  logic     cmd_enable;
  logic     line_step;
  coord_y_t dy_next;
  count_t   ny_next;
  logic     clr_load;
  pixel_t   clr_value;
  pixel_t   colmask;
  pixel_t   merged_byte;
  pixel_t   read_pixel;
  logic     pix_x_low;
  logic     is_byte_cmd;

  // Drawing only in a bitmap mode
  assign cmd_enable = mode_graphic_4 | mode_graphic_7;

  vdp_cmd_regs u_regs (
    .reset      (reset),
    .clk        (clk),
    .cmd_enable (cmd_enable),
    .reg_wr_req (reg_wr_req),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .ce         (ce),
    .line_step  (line_step),
    .dy_next    (dy_next),
    .ny_next    (ny_next),
    .clr_load   (clr_load),
    .clr_value  (clr_value),
    .colmask    (colmask),
    .reg_wr_ack (reg_wr_ack),
    .sx         (sx),
    .dx         (dx),
    .sy         (sy),
    .dy         (dy),
    .nx         (nx),
    .ny         (ny),
    .clr        (clr),
    .log_op     (log_op),
    .dix        (dix),
    .diy        (diy),
    .cmd        (current_command),
    .cmd_start  (cmd_start)
  );

  vdp_cmd_seq u_seq (
    .reset          (reset),
    .clk            (clk),
    .mode_graphic_4 (mode_graphic_4),
    .sx             (sx),
    .sy             (sy),
    .dx             (dx),
    .dy             (dy),
    .nx             (nx),
    .ny             (ny),
    .dix            (dix),
    .diy            (diy),
    .cmd            (current_command),
    .cmd_start      (cmd_start),
    .vram_rd_ack    (vram_rd_ack),
    .vram_wr_ack    (vram_wr_ack),
    .merged_byte    (merged_byte),
    .read_pixel     (read_pixel),
    .ce             (ce),
    .vram_rd_req    (vram_rd_req),
    .vram_wr_req    (vram_wr_req),
    .vram_addr      (vram_addr),
    .vram_wr_data   (vram_wr_data),
    .pix_x_low      (pix_x_low),
    .is_byte_cmd    (is_byte_cmd),
    .line_step      (line_step),
    .dy_next        (dy_next),
    .ny_next        (ny_next),
    .clr_load       (clr_load),
    .clr_value      (clr_value)
  );

  vdp_pixel_op u_pixel (
    .mode_graphic_4 (mode_graphic_4),
    .is_byte_cmd    (is_byte_cmd),
    .pix_x_low      (pix_x_low),
    .log_op         (log_op),
    .clr            (clr),
    .rd_byte        (vram_rd_data),
    .read_pixel     (read_pixel),
    .merged_byte    (merged_byte),
    .colmask        (colmask)
  );

endmodule

// ==== sim/vram_model.sv ====
`timescale 1ns/100ps
/*
  Behavioral VRAM of 128 KB
  Answers read and write toggle requests after a random delay
*/
module vram_model import vdp_cmd_pkg::*; (
  input  logic       reset,
  input  logic       clk,
  input  vram_addr_t addr,
  input  logic       rd_req,
  input  logic       wr_req,
  input  pixel_t     wr_data,
  output logic       rd_ack,
  output logic       wr_ack,
  output pixel_t     rd_data
);

  pixel_t mem [0:131071];
  integer seed;
  integer rd_wait;
  integer wr_wait;
  logic   rd_busy;
  logic   wr_busy;

  initial begin
    seed = 17585;
  end

  always @(posedge reset or posedge clk) begin
    if (clk) begin
      rd_ack  <= 1'b0;
      wr_ack  <= 1'b0;
      rd_busy <= 1'b0;
      wr_busy <= 1'b0;
      rd_wait <= 0;
      wr_wait <= 0;
      rd_data <= '0;
    end else begin
      // Read: pick a delay, count it down, then answer
      if (rd_req != rd_ack) begin
        if (!rd_busy) begin
          rd_busy <= 1'b1;
          rd_wait <= {$random(seed)} % 4;
        end else if (rd_wait == 0) begin
          rd_data <= mem[addr];
          rd_ack  <= rd_req;
          rd_busy <= 1'b0;
        end else begin
          rd_wait <= rd_wait - 1;
        end
      end
      // Write works the same way
      if (wr_req != wr_ack) begin
        if (!wr_busy) begin
          wr_busy <= 1'b1;
          wr_wait <= {$random(seed)} % 4;
        end else if (wr_wait == 0) begin
          mem[addr] <= wr_data;
          wr_ack    <= wr_req;
          wr_busy   <= 1'b0;
        end else begin
          wr_wait <= wr_wait - 1;
        end
      end
    end
  end

endmodule

// ==== sim/tb_vdp_cmd.sv ====
`timescale 1ns/100ps
/*
  Testbench for the VDP command engine
  Runs a table of drawing commands against a shadow VRAM
  and compares the real VRAM around every drawn area
*/
module tb_vdp_cmd import vdp_cmd_pkg::*;;

  localparam int REG_TIMEOUT = 16;
  localparam int CMD_TIMEOUT = 5000;
  localparam int TR          = 1 << OP_T_BIT;

  typedef struct packed {
    logic      g4;
    cmd_code_t cmd;
    log_op_t   op;
    coord_x_t  sx;
    coord_y_t  sy;
    coord_x_t  dx;
    coord_y_t  dy;
    count_t    nx;
    count_t    ny;
    logic      dix;
    logic      diy;
    pixel_t    clr;
    pixel_t    exp_clr;
    logic      abort;
  } test_row_t;

  // Clock and reset as the DUT names them
  logic       reset;
  logic       clk;
  logic       mode_graphic_4;
  logic       mode_graphic_7;
  logic       reg_wr_req;
  reg_num_t   reg_num;
  pixel_t     reg_data;
  logic       reg_wr_ack;
  logic       vram_wr_req;
  logic       vram_rd_req;
  logic       vram_wr_ack;
  logic       vram_rd_ack;
  vram_addr_t vram_addr;
  pixel_t     vram_wr_data;
  pixel_t     vram_rd_data;
  pixel_t     clr;
  logic       ce;
  cmd_code_t  current_command;

  test_row_t rows [0:39];
  int        num_rows;
  pixel_t    shadow [0:131071];
  // Byte window touched by the last command
  int        min_col;
  int        max_col;
  int        min_row;
  int        max_row;

  vdp_cmd_top DUT (
    .reset           (reset),
    .clk             (clk),
    .mode_graphic_4  (mode_graphic_4),
    .mode_graphic_7  (mode_graphic_7),
    .reg_wr_req      (reg_wr_req),
    .reg_num         (reg_num),
    .reg_data        (reg_data),
    .vram_wr_ack     (vram_wr_ack),
    .vram_rd_ack     (vram_rd_ack),
    .vram_rd_data    (vram_rd_data),
    .reg_wr_ack      (reg_wr_ack),
    .vram_wr_req     (vram_wr_req),
    .vram_rd_req     (vram_rd_req),
    .vram_addr       (vram_addr),
    .vram_wr_data    (vram_wr_data),
    .clr             (clr),
    .ce              (ce),
    .current_command (current_command)
  );

  vram_model u_vram (
    .reset   (reset),
    .clk     (clk),
    .addr    (vram_addr),
    .rd_req  (vram_rd_req),
    .wr_req  (vram_wr_req),
    .wr_data (vram_wr_data),
    .rd_ack  (vram_rd_ack),
    .wr_ack  (vram_wr_ack),
    .rd_data (vram_rd_data)
  );

  initial begin
    reset = 1'b0;
    forever #10 reset = ~reset;
  end

  task automatic stop_on_failure();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    stop_on_failure();
  endtask

  // Initial VRAM contents from all address bits
  function automatic pixel_t fill_byte(input int a);
    logic [16:0] v;
    v = a[16:0];
    return v[7:0] ^ v[15:8] ^ {v[16], 7'h00} ^ 8'h96;
  endfunction

  function automatic int byte_addr(input logic g4, input int x, input int y);
    return g4 ? y * 128 + x / 2 : y * 256 + x;
  endfunction

  // Logical operation on a masked source and a destination pixel
  function automatic pixel_t logic_result(input log_op_t op, input pixel_t src,
                                          input pixel_t dst);
    pixel_t res;
    case (op[2:0])
      3'd0:    res = src;
      3'd1:    res = src & dst;
      3'd2:    res = src | dst;
      3'd3:    res = src ^ dst;
      3'd4:    res = ~src;
      default: res = dst;
    endcase
    if (op[OP_T_BIT] && src == 8'h00) begin
      res = dst;
    end
    return res;
  endfunction

  task automatic add_row(input int g4, input int cmd, input int op, input int sx, input int sy,
                         input int dx, input int dy, input int nx, input int ny,
                         input int dix, input int diy, input int colour, input int exp_clr,
                         input int abort);
    test_row_t r;
    r.g4      = g4[0];
    r.cmd     = cmd[3:0];
    r.op      = op[3:0];
    r.sx      = sx[8:0];
    r.sy      = sy[9:0];
    r.dx      = dx[8:0];
    r.dy      = dy[9:0];
    r.nx      = nx[9:0];
    r.ny      = ny[9:0];
    r.dix     = dix[0];
    r.diy     = diy[0];
    r.clr     = colour[7:0];
    r.exp_clr = exp_clr[7:0];
    r.abort   = abort[0];
    rows[num_rows] = r;
    num_rows++;
  endtask

  task automatic load_table();
    num_rows = 0;
    // Byte fills in both modes plus one drawn leftward and upward
    add_row(0, CMD_HMMV, OP_IMP, 0, 0, 10, 5, 6, 3, 0, 0, 'hA5, 0, 0);
    add_row(1, CMD_HMMV, OP_IMP, 0, 0, 20, 8, 10, 2, 0, 0, 'h3C, 0, 0);
    add_row(1, CMD_HMMV, OP_IMP, 0, 0, 9, 12, 8, 3, 1, 1, 'hE1, 0, 0);
    // Graphic 7 logical fills
    add_row(0, CMD_LMMV, OP_IMP, 0, 0, 30, 60, 4, 2, 0, 0, 'hA5, 0, 0);
    add_row(0, CMD_LMMV, OP_IMP + TR, 0, 0, 30, 63, 4, 2, 0, 0, 'h00, 0, 0);
    add_row(0, CMD_LMMV, OP_AND, 0, 0, 30, 66, 4, 2, 0, 0, 'h3C, 0, 0);
    add_row(0, CMD_LMMV, OP_AND + TR, 0, 0, 30, 69, 4, 2, 0, 0, 'hC3, 0, 0);
    add_row(0, CMD_LMMV, OP_OR, 0, 0, 30, 72, 4, 2, 0, 0, 'h12, 0, 0);
    add_row(0, CMD_LMMV, OP_OR + TR, 0, 0, 30, 75, 4, 2, 0, 0, 'h00, 0, 0);
    add_row(0, CMD_LMMV, OP_XOR, 0, 0, 30, 78, 4, 2, 0, 0, 'hFF, 0, 0);
    add_row(0, CMD_LMMV, OP_XOR + TR, 0, 0, 30, 81, 4, 2, 0, 0, 'h5A, 0, 0);
    add_row(0, CMD_LMMV, OP_NOT, 0, 0, 30, 84, 4, 2, 0, 0, 'h0F, 0, 0);
    add_row(0, CMD_LMMV, OP_NOT + TR, 0, 0, 30, 87, 4, 2, 0, 0, 'h00, 0, 0);
    // Graphic 4 logical fills from an odd X so both nibbles get hit
    add_row(1, CMD_LMMV, OP_IMP, 0, 0, 31, 100, 5, 2, 0, 0, 'h0A, 0, 0);
    add_row(1, CMD_LMMV, OP_IMP + TR, 0, 0, 31, 103, 5, 2, 0, 0, 'h30, 0, 0);
    add_row(1, CMD_LMMV, OP_AND, 0, 0, 31, 106, 5, 2, 0, 0, 'h06, 0, 0);
    add_row(1, CMD_LMMV, OP_AND + TR, 0, 0, 31, 109, 5, 2, 0, 0, 'h0C, 0, 0);
    add_row(1, CMD_LMMV, OP_OR, 0, 0, 31, 112, 5, 2, 0, 0, 'h09, 0, 0);
    add_row(1, CMD_LMMV, OP_OR + TR, 0, 0, 31, 115, 5, 2, 0, 0, 'h00, 0, 0);
    add_row(1, CMD_LMMV, OP_XOR, 0, 0, 31, 118, 5, 2, 0, 0, 'h0F, 0, 0);
    add_row(1, CMD_LMMV, OP_XOR + TR, 0, 0, 31, 121, 5, 2, 0, 0, 'h05, 0, 0);
    add_row(1, CMD_LMMV, OP_NOT, 0, 0, 31, 124, 5, 2, 0, 0, 'h03, 0, 0);
    add_row(1, CMD_LMMV, OP_NOT + TR, 0, 0, 31, 127, 5, 2, 0, 0, 'hF0, 0, 0);
    // Rows cut short at the X edge and at line zero
    add_row(0, CMD_LMMV, OP_XOR, 0, 0, 252, 90, 10, 2, 0, 0, 'h33, 0, 0);
    add_row(0, CMD_LMMV, OP_OR, 0, 0, 3, 1, 8, 5, 1, 1, 'h44, 0, 0);
    add_row(1, CMD_LMMV, OP_IMP, 0, 0, 4, 140, 3, 3, 1, 1, 'h07, 0, 0);
    add_row(0, CMD_HMMV, OP_IMP, 0, 0, 250, 95, 20, 2, 0, 0, 'h77, 0, 0);
    add_row(1, CMD_HMMV, OP_IMP, 0, 0, 248, 145, 20, 1, 0, 0, 'h9E, 0, 0);
    // Single pixels written and read back
    add_row(1, CMD_PSET, OP_IMP, 0, 0, 33, 20, 0, 0, 0, 0, 'h0B, 0, 0);
    add_row(1, CMD_POINT, OP_IMP, 33, 20, 0, 0, 0, 0, 0, 0, 'h00, 'h0B, 0);
    add_row(1, CMD_PSET, OP_IMP, 0, 0, 34, 20, 0, 0, 0, 0, 'h07, 0, 0);
    add_row(1, CMD_POINT, OP_IMP, 34, 20, 0, 0, 0, 0, 0, 0, 'h00, 'h07, 0);
    add_row(0, CMD_PSET, OP_IMP, 0, 0, 10, 30, 0, 0, 0, 0, 'hC3, 0, 0);
    add_row(0, CMD_POINT, OP_IMP, 10, 30, 0, 0, 0, 0, 0, 0, 'h00, 'hC3, 0);
    // LMMV cut off by an HMMV over the same rectangle
    add_row(0, CMD_LMMV, OP_XOR, 0, 0, 40, 40, 12, 2, 0, 0, 'h5A, 0, 1);
  endtask

  task automatic write_reg(input reg_num_t num, input pixel_t data);
    int cycles;
    @(negedge reset);
    reg_num    = num;
    reg_data   = data;
    reg_wr_req = ~reg_wr_req;
    cycles     = 0;
    while (reg_wr_ack !== reg_wr_req) begin
      @(negedge reset);
      cycles++;
      if (cycles > REG_TIMEOUT) begin
        report_timeout("a register write was never acknowledged");
      end
    end
  endtask

  task automatic wait_ce(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (ce !== level) begin
      @(negedge reset);
      cycles++;
      if (cycles > CMD_TIMEOUT) begin
        report_timeout(what);
      end
    end
  endtask

  task automatic wait_write_acks(input int count);
    logic last;
    int   seen;
    int   cycles;
    last   = vram_wr_ack;
    seen   = 0;
    cycles = 0;
    while (seen < count) begin
      @(negedge reset);
      cycles++;
      if (vram_wr_ack !== last) begin
        seen++;
        last = vram_wr_ack;
      end
      if (cycles > CMD_TIMEOUT) begin
        report_timeout("the running LMMV never wrote to VRAM");
      end
    end
  endtask

  task automatic note_byte(input logic g4, input int x, input int y);
    int col;
    col = g4 ? x / 2 : x;
    if (col < min_col) min_col = col;
    if (col > max_col) max_col = col;
    if (y < min_row) min_row = y;
    if (y > max_row) max_row = y;
  endtask

  // One pixel of the shadow VRAM
  task automatic model_pixel(input logic g4, input logic byte_cmd, input int x, input int y,
                             input log_op_t op, input pixel_t colour);
    int     a;
    pixel_t old;
    pixel_t nib;
    pixel_t res;
    a   = byte_addr(g4, x, y);
    old = shadow[a];
    if (byte_cmd) begin
      shadow[a] = colour;
    end else if (g4) begin
      nib = (x % 2) ? {4'h0, old[3:0]} : {4'h0, old[7:4]};
      res = logic_result(op, colour & 8'h0F, nib);
      shadow[a] = (x % 2) ? {old[7:4], res[3:0]} : {res[3:0], old[3:0]};
    end else begin
      shadow[a] = logic_result(op, colour, old);
    end
    note_byte(g4, x, y);
  endtask

  task automatic model_command(input test_row_t r);
    cmd_code_t c;
    logic      byte_cmd;
    logic      done;
    int        x;
    int        y;
    int        n;
    int        step;
    int        rows_left;
    c        = r.abort ? CMD_HMMV : r.cmd;
    byte_cmd = (c == CMD_HMMV);
    min_col  = 1 << 20;
    max_col  = -1;
    min_row  = 1 << 20;
    max_row  = -1;
    if (c == CMD_POINT) begin
      note_byte(r.g4, r.sx, r.sy);
    end else if (c == CMD_PSET) begin
      model_pixel(r.g4, 1'b0, r.dx, r.dy, r.op, r.clr);
    end else begin
      step      = (byte_cmd && r.g4) ? 2 : 1;
      step      = r.dix ? -step : step;
      y         = r.dy;
      rows_left = r.ny;
      done      = 1'b0;
      while (!done) begin
        x = r.dx;
        n = (byte_cmd && r.g4) ? r.nx / 2 : r.nx;
        // A row ends on its count or past the screen edge
        do begin
          model_pixel(r.g4, byte_cmd, x, y, r.op, r.clr);
          x = x + step;
          n = n - 1;
        end while (n > 0 && x >= 0 && x < 256);
        if (rows_left == 1 || (r.diy && y == 0)) begin
          done = 1'b1;
        end else begin
          y         = r.diy ? y - 1 : y + 1;
          rows_left = rows_left - 1;
        end
      end
    end
  endtask

  // Drawn bytes plus a one byte border all round
  task automatic compare_window(input logic g4);
    int y;
    int col;
    int a;
    int last_col;
    last_col = g4 ? 127 : 255;
    for (y = (min_row > 0) ? min_row - 1 : 0; y <= max_row + 1; y++) begin
      for (col = (min_col > 0) ? min_col - 1 : 0; col <= max_col + 1; col++) begin
        if (col <= last_col) begin
          a = g4 ? y * 128 + col : y * 256 + col;
          check_value($sformatf("vram[%05h]", a), u_vram.mem[a], shadow[a]);
        end
      end
    end
  endtask

  task automatic run_row(input test_row_t r);
    @(negedge reset);
    mode_graphic_4 = r.g4;
    mode_graphic_7 = ~r.g4;
    write_reg(REG_SX_L, r.sx[7:0]);
    write_reg(REG_SX_H, {7'h00, r.sx[8]});
    write_reg(REG_SY_L, r.sy[7:0]);
    write_reg(REG_SY_H, {6'h00, r.sy[9:8]});
    write_reg(REG_DX_L, r.dx[7:0]);
    write_reg(REG_DX_H, {7'h00, r.dx[8]});
    write_reg(REG_DY_L, r.dy[7:0]);
    write_reg(REG_DY_H, {6'h00, r.dy[9:8]});
    write_reg(REG_NX_L, r.nx[7:0]);
    write_reg(REG_NX_H, {6'h00, r.nx[9:8]});
    write_reg(REG_NY_L, r.ny[7:0]);
    write_reg(REG_NY_H, {6'h00, r.ny[9:8]});
    write_reg(REG_CLR, r.clr);
    write_reg(REG_ARG, {4'h0, r.diy, r.dix, 2'b00});
    write_reg(REG_CMR, {r.cmd, r.op});
    wait_ce(1'b1, "ce never rose after the command write");
    if (r.abort) begin
      // New command write while the LMMV is mid row
      wait_write_acks(3);
      write_reg(REG_CMR, {CMD_HMMV, OP_IMP});
    end
    wait_ce(1'b0, "ce never fell at the end of the command");
    // Code of the last command written to CMR
    check_value("current_command", current_command, r.abort ? CMD_HMMV : r.cmd);
    model_command(r);
    compare_window(r.g4);
    if (r.cmd == CMD_POINT) begin
      check_value("clr", clr, r.exp_clr);
      check_value("clr", clr, r.g4 ? (r.sx[0] ? shadow[byte_addr(1'b1, r.sx, r.sy)] & 8'h0F
                                               : shadow[byte_addr(1'b1, r.sx, r.sy)] >> 4)
                                   : shadow[byte_addr(1'b0, r.sx, r.sy)]);
    end
  endtask

  initial begin
    int i;
    clk            = 1'b1;
    mode_graphic_4 = 1'b0;
    mode_graphic_7 = 1'b0;
    reg_wr_req     = 1'b0;
    reg_num        = '0;
    reg_data       = '0;
    for (i = 0; i < 131072; i++) begin
      u_vram.mem[i] = fill_byte(i);
      shadow[i]     = fill_byte(i);
    end
    load_table();
    repeat (3) @(posedge reset);
    @(negedge reset);
    clk = 1'b0;
    @(negedge reset);
    // Idle outputs after reset
    check_value("ce", ce, 1'b0);
    check_value("vram_rd_req", vram_rd_req, 1'b0);
    check_value("vram_wr_req", vram_wr_req, 1'b0);
    check_value("reg_wr_ack", reg_wr_ack, 1'b0);
    check_value("clr", clr, 8'h00);
    for (i = 0; i < num_rows; i++) begin
      run_row(rows[i]);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/vdp_cmd_pkg.sv
src/vdp_cmd_regs.sv
src/vdp_cmd_seq.sv
src/vdp_pixel_op.sv
src/vdp_cmd_top.sv
sim/vram_model.sv
sim/tb_vdp_cmd.sv
